//--- verilog.f
design/main_mem_pkg.sv
design/mem_port_ctrl.sv
design/mem_access_arbiter.sv
design/line_store.sv
design/main_memory.sv
bench/mem_checker.sv
bench/main_memory_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the main memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module main_memory_tb \
        -f verilog.f --Mdir obj_dir -o main_memory_sim; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/main_memory_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Done: no errors" <<< "$sim_out"; then
    exit 0
fi
echo "simulation reported failure"
exit 1

//--- bench/main_memory_tb.sv
`timescale 1ns/1ps
`default_nettype none

module main_memory_tb;

    localparam int NP          = main_mem_pkg::NUM_PORTS;
    localparam int LB          = main_mem_pkg::LINE_BITS;
    localparam int AB          = main_mem_pkg::ADDR_BITS;
    localparam int NUM_RAND    = 150;                 // random requests per port
    localparam int READY_LEN   = 1024;                // resp_ready pattern replayed in a loop
    localparam int TOTAL_REQ   = 8 + NP * NUM_RAND;   // directed plus random
    localparam int LIMIT       = TOTAL_REQ * (main_mem_pkg::ACCESS_LATENCY + 20) + 100;
    localparam int DRAIN_LIMIT = 4 * (main_mem_pkg::ACCESS_LATENCY + 20); // last answers

    logic                  clk        = 1'b0;
    logic                  reset      = 1'b1;
    logic [NP-1:0]         req_valid  = '0;
    logic [NP-1:0]         req_write  = '0;
    logic [NP-1:0][AB-1:0] req_addr   = '0;
    logic [NP-1:0][LB-1:0] req_wdata  = '0;
    logic [NP-1:0]         resp_ready = '0;
    logic                  end_of_run = 1'b0;
    wire  [NP-1:0]         req_ready;
    wire  [NP-1:0]         resp_valid;
    wire  [NP-1:0][LB-1:0] resp_rdata;
    int                    error_count;
    int                    check_count;

    logic [31:0]   lfsr;
    int            req_cnt [NP] = '{0, 0};
    int            resp_cnt [NP] = '{0, 0};
    int            test_checks;            // counts at start of the current test
    int            test_errors;
    int            ready_idx = 0;
    logic [11:0]   pool [16];              // shared lines so the ports collide
    logic          rnd_write [NP][NUM_RAND];
    logic [AB-1:0] rnd_addr [NP][NUM_RAND];
    logic [LB-1:0] rnd_data [NP][NUM_RAND];
    int            rnd_gap [NP][NUM_RAND];
    logic [NP-1:0] ready_pat [READY_LEN];

    always #2 clk = ~clk;

    main_memory dut0 (
        .clk             (clk),
        .reset           (reset),
        .imem_req_valid  (req_valid[0]),
        .imem_req_ready  (req_ready[0]),
        .imem_req_write  (req_write[0]),
        .imem_req_addr   (req_addr[0]),
        .imem_req_wdata  (req_wdata[0]),
        .imem_resp_valid (resp_valid[0]),
        .imem_resp_rdata (resp_rdata[0]),
        .imem_resp_ready (resp_ready[0]),
        .dmem_req_valid  (req_valid[1]),
        .dmem_req_ready  (req_ready[1]),
        .dmem_req_write  (req_write[1]),
        .dmem_req_addr   (req_addr[1]),
        .dmem_req_wdata  (req_wdata[1]),
        .dmem_resp_valid (resp_valid[1]),
        .dmem_resp_rdata (resp_rdata[1]),
        .dmem_resp_ready (resp_ready[1])
    );

    mem_checker chk (.*);

    // galois form with taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [LB-1:0] rand_bits(input int n);
        logic [LB-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0]; // one step per bit
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    task automatic build_random_plan();
        for (int i = 0; i < 16; i++) begin
            pool[i] = (i == 0) ? 12'h100 : 12'(rand_bits(12)); // boot line always in
        end
        for (int p = 0; p < NP; p++) begin
            for (int i = 0; i < NUM_RAND; i++) begin
                rnd_write[p][i] = 1'(rand_bits(1));
                rnd_addr[p][i]  = {16'h0, pool[4'(rand_bits(4))], 4'(rand_bits(4))};
                rnd_data[p][i]  = rand_bits(LB);
                rnd_gap[p][i]   = int'(rand_bits(2));
            end
        end
        for (int i = 0; i < READY_LEN; i++) begin
            for (int p = 0; p < NP; p++) begin
                ready_pat[i][p] = |(2'(rand_bits(2))); // ready three times in four
            end
        end
    endtask

    task automatic issue(input int p, input logic wr, input logic [AB-1:0] addr,
                         input logic [LB-1:0] data);
        @(posedge clk);
        req_valid[p] <= 1'b1;
        req_write[p] <= wr;
        req_addr[p]  <= addr;
        req_wdata[p] <= data;
        @(negedge clk);
        while (!req_ready[p]) begin
            @(negedge clk);
        end
        @(posedge clk); // handshake edge
        req_valid[p] <= 1'b0;
        req_cnt[p]++;
    endtask

    task automatic request_and_wait(input int p, input logic wr, input logic [AB-1:0] addr,
                                    input logic [LB-1:0] data);
        int target;
        target = resp_cnt[p] + 1;
        issue(p, wr, addr, data);
        while (resp_cnt[p] < target) begin
            @(negedge clk);
        end
    endtask

    task automatic port_traffic(input int p);
        for (int i = 0; i < NUM_RAND; i++) begin
            repeat (rnd_gap[p][i]) @(posedge clk);
            issue(p, rnd_write[p][i], rnd_addr[p][i], rnd_data[p][i]);
        end
    endtask

    task automatic start_test();
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic print_test_line(input string name);
        $display("test %s: %0d checks, %0d errors", name,
                 check_count - test_checks, error_count - test_errors);
    endtask

    always @(posedge clk) begin
        resp_ready <= ready_pat[ready_idx]; // back-pressure throughout
        ready_idx  <= (ready_idx + 1) % READY_LEN;
    end

    // counted on the transfer edge
    always @(posedge clk) begin
        for (int p = 0; p < NP; p++) begin
            if (resp_valid[p] && resp_ready[p]) begin
                resp_cnt[p]++;
            end
        end
    end

    initial begin
        logic [LB-1:0] d;
        int            drain;
        lfsr = 32'd9;
        build_random_plan();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        start_test();
        request_and_wait(0, 1'b0, 32'h0000_1000, '0); // boot line 0x100
        request_and_wait(0, 1'b0, 32'h0000_3FF4, '0); // never written
        print_test_line("1 boot and nop reads");
        start_test();
        d = rand_bits(LB);
        request_and_wait(1, 1'b1, 32'h0000_5A3C, d);
        request_and_wait(1, 1'b0, 32'h0000_5A31, '0); // other low nibble
        print_test_line("2 write then read, same port");
        start_test();
        d = rand_bits(LB);
        request_and_wait(1, 1'b1, 32'h0000_6000, d);
        request_and_wait(0, 1'b0, 32'h0000_600B, '0);
        d = rand_bits(LB);
        request_and_wait(0, 1'b1, 32'h0000_7004, d);
        request_and_wait(1, 1'b0, 32'h0000_700F, '0);
        print_test_line("3 cross-port sharing");
        start_test();
        fork
            port_traffic(0);
            port_traffic(1);
        join
        drain = 0;
        while ((resp_cnt[0] < req_cnt[0] || resp_cnt[1] < req_cnt[1]) &&
               drain < DRAIN_LIMIT) begin
            @(negedge clk);
            drain++;
        end
        print_test_line("4 random concurrent traffic");
        @(posedge clk);
        end_of_run <= 1'b1;
        repeat (2) @(negedge clk);
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog sized from the request count
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("run timed out after %0d cycles, a port hung or a response was lost", LIMIT);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_checker (
    input  wire logic                                                      clk,
    input  wire logic                                                      reset,
    input  wire logic [main_mem_pkg::NUM_PORTS-1:0]                        req_valid,
    input  wire logic [main_mem_pkg::NUM_PORTS-1:0]                        req_ready,
    input  wire logic [main_mem_pkg::NUM_PORTS-1:0]                        req_write,
    input  wire logic [main_mem_pkg::NUM_PORTS-1:0][main_mem_pkg::ADDR_BITS-1:0] req_addr,
    input  wire logic [main_mem_pkg::NUM_PORTS-1:0][main_mem_pkg::LINE_BITS-1:0] req_wdata,
    input  wire logic [main_mem_pkg::NUM_PORTS-1:0]                        resp_valid,
    input  wire logic [main_mem_pkg::NUM_PORTS-1:0]                        resp_ready,
    input  wire logic [main_mem_pkg::NUM_PORTS-1:0][main_mem_pkg::LINE_BITS-1:0] resp_rdata,
    input  wire logic                                                      end_of_run,
    output int                                                             error_count,
    output int                                                             check_count
);

    localparam int NP      = main_mem_pkg::NUM_PORTS;
    localparam int LB      = main_mem_pkg::LINE_BITS;
    localparam int MIN_LAT = main_mem_pkg::ACCESS_LATENCY + 1; // accept edge to first resp_valid

    logic [LB-1:0] model [main_mem_pkg::MEM_LINES]; // what the store should hold
    logic [NP-1:0] busy;               // accepted and answer not taken yet
    logic [NP-1:0] seen;               // first response cycle handled
    logic [NP-1:0] held;               // valid without ready last cycle
    logic [NP-1:0] xfer;               // answer taken last cycle
    logic [NP-1:0] iso;                // other port idle for the whole request
    logic [NP-1:0] is_write;
    logic [11:0]   line_q [NP];        // addr[15:4]
    logic [31:0]   addr_q [NP];
    logic [LB-1:0] wdata_q [NP];
    logic [LB-1:0] last_rdata [NP];
    int            acc_cyc [NP];       // negedge count just after the accept edge
    int            cyc = 0;
    int            errors = 0;
    int            checks = 0;
    logic          end_done;

    assign error_count = errors;
    assign check_count = checks;

    function automatic string port_name(input int p);
        return (p == 0) ? "imem" : "dmem";
    endfunction

    // nop in every word and the boot image from word 0x400 with word 0 in the low bits
    initial begin
        int w;
        for (int l = 0; l < main_mem_pkg::MEM_LINES; l++) begin
            model[l] = {4{main_mem_pkg::NOP_WORD}};
        end
        for (int b = 0; b < 3; b++) begin
            w = main_mem_pkg::BOOT_WORD_BASE + b;
            model[w / 4][(w % 4) * 32 +: 32] = main_mem_pkg::BOOT_WORDS[b * 32 +: 32];
        end
    end

    // sampled on the falling edge when everything has settled
    always @(negedge clk) begin
        logic [NP-1:0] acc_now;
        logic [LB-1:0] expected;
        int            lat;
        int            q;
        cyc++;
        if (reset) begin
            busy     = '0;
            seen     = '0;
            held     = '0;
            xfer     = '0;
            iso      = '0;
            end_done = 1'b0;
            if (req_ready != '1 || resp_valid != '0) begin
                errors++;
                $display("ports not idle during reset: req_ready %b resp_valid %b",
                         req_ready, resp_valid);
            end
        end else begin
            acc_now = req_valid & req_ready; // transfers on the coming rising edge
            // reads first so a write appearing now is not seen by them
            for (int p = 0; p < NP; p++) begin
                if (resp_valid[p] && !seen[p]) begin
                    if (!busy[p]) begin
                        errors++;
                        $display("%s port gave an extra response with nothing outstanding",
                                 port_name(p));
                    end else begin
                        lat = cyc - acc_cyc[p];
                        if (lat < MIN_LAT || (iso[p] && lat != MIN_LAT)) begin
                            errors++;
                            $display("%s port answered %0d cycles after accept, time %0t",
                                     port_name(p), lat, $time);
                        end
                        expected = is_write[p] ? '0 : model[line_q[p]]; // writes answer zero
                        checks++;
                        if (resp_rdata[p] !== expected) begin
                            errors++;
                            $display("Mismatch at time %0t: %s port addr %h expected %h actual %h",
                                     $time, port_name(p), addr_q[p], expected, resp_rdata[p]);
                        end
                    end
                end
            end
            for (int p = 0; p < NP; p++) begin
                q = NP - 1 - p;
                if (resp_valid[p] && !seen[p] && busy[p] && is_write[p]) begin
                    model[line_q[p]] = wdata_q[p]; // visible from its first response cycle
                end
                if (resp_valid[p]) begin
                    seen[p] = 1'b1;
                end
                if (held[p] && (!resp_valid[p] || resp_rdata[p] !== last_rdata[p])) begin
                    errors++;
                    $display("%s port dropped or changed its response while resp_ready was low",
                             port_name(p));
                end
                if (busy[p] && req_ready[p]) begin
                    errors++;
                    $display("%s port raised req_ready with a request outstanding", port_name(p));
                end
                if (xfer[p] && !req_ready[p]) begin
                    errors++;
                    $display("%s port kept req_ready low after its response was taken",
                             port_name(p));
                end
                held[p]       = resp_valid[p] && !resp_ready[p];
                xfer[p]       = resp_valid[p] && resp_ready[p];
                last_rdata[p] = resp_rdata[p];
                if (xfer[p]) begin
                    busy[p] = 1'b0;
                    seen[p] = 1'b0;
                end
                if (acc_now[p]) begin
                    busy[p]     = 1'b1;
                    is_write[p] = req_write[p];
                    addr_q[p]   = req_addr[p];
                    line_q[p]   = req_addr[p][15:4]; // low nibble and high half ignored
                    wdata_q[p]  = req_wdata[p];
                    acc_cyc[p]  = cyc + 1; // accept edge comes after this sample
                    iso[p]      = !busy[q] && !acc_now[q];
                    if (busy[q]) begin
                        iso[q] = 1'b0; // overlap may delay the other one too
                    end
                end
            end
            if (end_of_run && !end_done) begin
                end_done = 1'b1;
                for (int p = 0; p < NP; p++) begin
                    if (busy[p]) begin
                        errors++;
                        $display("%s port lost the response to its request at addr %h",
                                 port_name(p), addr_q[p]);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/main_memory.sv
`timescale 1ns/1ps
`default_nettype none

module main_memory (
    input  wire logic                                clk,
    input  wire logic                                reset,

    // instruction side
    input  wire logic                                imem_req_valid,
    output logic                                     imem_req_ready,
    input  wire logic                                imem_req_write,
    input  wire logic [main_mem_pkg::ADDR_BITS-1:0]  imem_req_addr,
    input  wire logic [main_mem_pkg::LINE_BITS-1:0]  imem_req_wdata,
    output logic                                     imem_resp_valid,
    output logic [main_mem_pkg::LINE_BITS-1:0]       imem_resp_rdata,
    input  wire logic                                imem_resp_ready,

    // data side
    input  wire logic                                dmem_req_valid,
    output logic                                     dmem_req_ready,
    input  wire logic                                dmem_req_write,
    input  wire logic [main_mem_pkg::ADDR_BITS-1:0]  dmem_req_addr,
    input  wire logic [main_mem_pkg::LINE_BITS-1:0]  dmem_req_wdata,
    output logic                                     dmem_resp_valid,
    output logic [main_mem_pkg::LINE_BITS-1:0]       dmem_resp_rdata,
    input  wire logic                                dmem_resp_ready
);

    // controller to arbiter, index 0 = imem, 1 = dmem
    logic [main_mem_pkg::NUM_PORTS-1:0]                                 acc_req;
    logic [main_mem_pkg::NUM_PORTS-1:0]                                 acc_write;
    logic [main_mem_pkg::NUM_PORTS-1:0]                                 acc_grant;
    logic [main_mem_pkg::NUM_PORTS-1:0][main_mem_pkg::LINE_IDX_BITS-1:0] acc_line;
    logic [main_mem_pkg::NUM_PORTS-1:0][main_mem_pkg::LINE_BITS-1:0]     acc_wdata;

    // arbiter to store
    logic                                   store_en;
    logic                                   store_we;
    logic [main_mem_pkg::LINE_IDX_BITS-1:0] store_line;
    logic [main_mem_pkg::LINE_BITS-1:0]     store_wdata;
    logic [main_mem_pkg::LINE_BITS-1:0]     store_rdata; // shared by both controllers

    mem_port_ctrl imem_port (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (imem_req_valid),
        .req_ready   (imem_req_ready),
        .req_write   (imem_req_write),
        .req_addr    (imem_req_addr),
        .req_wdata   (imem_req_wdata),
        .resp_valid  (imem_resp_valid),
        .resp_rdata  (imem_resp_rdata),
        .resp_ready  (imem_resp_ready),
        .acc_req     (acc_req[0]),
        .acc_grant   (acc_grant[0]),
        .acc_write   (acc_write[0]),
        .acc_line    (acc_line[0]),
        .acc_wdata   (acc_wdata[0]),
        .store_rdata (store_rdata)
    );

    mem_port_ctrl dmem_port (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (dmem_req_valid),
        .req_ready   (dmem_req_ready),
        .req_write   (dmem_req_write),
        .req_addr    (dmem_req_addr),
        .req_wdata   (dmem_req_wdata),
        .resp_valid  (dmem_resp_valid),
        .resp_rdata  (dmem_resp_rdata),
        .resp_ready  (dmem_resp_ready),
        .acc_req     (acc_req[1]),
        .acc_grant   (acc_grant[1]),
        .acc_write   (acc_write[1]),
        .acc_line    (acc_line[1]),
        .acc_wdata   (acc_wdata[1]),
        .store_rdata (store_rdata)
    );

    mem_access_arbiter arb (
        .clk         (clk),
        .reset       (reset),
        .acc_req     (acc_req),
        .acc_write   (acc_write),
        .acc_line    (acc_line),
        .acc_wdata   (acc_wdata),
        .acc_grant   (acc_grant),
        .store_en    (store_en),
        .store_we    (store_we),
        .store_line  (store_line),
        .store_wdata (store_wdata)
    );

    line_store store (
        .clk   (clk),
        .en    (store_en),
        .we    (store_we),
        .line  (store_line),
        .wdata (store_wdata),
        .rdata (store_rdata)
    );

endmodule

`default_nettype wire

//--- design/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input  wire logic                                clk,
    input  wire logic                                en,
    input  wire logic                                we,
    input  wire logic [main_mem_pkg::LINE_IDX_BITS-1:0] line,
    input  wire logic [main_mem_pkg::LINE_BITS-1:0]  wdata,
    output logic [main_mem_pkg::LINE_BITS-1:0]       rdata
);

    logic [main_mem_pkg::LINE_BITS-1:0] mem [main_mem_pkg::MEM_LINES]; // one entry per line

    // preload nop everywhere and then the boot sequence
    initial begin
        int w;       // absolute word index
        int l;       // line holding that word
        int slot;    // word position inside the line
        for (int i = 0; i < main_mem_pkg::MEM_LINES; i++) begin
            mem[i] = {main_mem_pkg::LINE_WORDS{main_mem_pkg::NOP_WORD}};
        end
        for (int b = 0; b < main_mem_pkg::BOOT_COUNT; b++) begin
            w    = main_mem_pkg::BOOT_WORD_BASE + b;
            l    = w / main_mem_pkg::LINE_WORDS;
            slot = w % main_mem_pkg::LINE_WORDS;
            mem[l][slot*main_mem_pkg::WORD_BITS +: main_mem_pkg::WORD_BITS] =
                main_mem_pkg::BOOT_WORDS[b*main_mem_pkg::WORD_BITS +: main_mem_pkg::WORD_BITS];
        end
    end

    // single port write or registered read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[line] <= wdata; // whole line without byte enables
            end else begin
                rdata <= mem[line]; // valid next cycle
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mem_access_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_arbiter (
    input  wire logic                                                         clk,
    input  wire logic                                                         reset,
    input  wire logic [main_mem_pkg::NUM_PORTS-1:0]                           acc_req,
    input  wire logic [main_mem_pkg::NUM_PORTS-1:0]                           acc_write,
    input  wire logic [main_mem_pkg::NUM_PORTS-1:0][main_mem_pkg::LINE_IDX_BITS-1:0] acc_line,
    input  wire logic [main_mem_pkg::NUM_PORTS-1:0][main_mem_pkg::LINE_BITS-1:0]     acc_wdata,
    output logic [main_mem_pkg::NUM_PORTS-1:0]                                acc_grant,
    output logic                                                              store_en,
    output logic                                                              store_we,
    output logic [main_mem_pkg::LINE_IDX_BITS-1:0]                            store_line,
    output logic [main_mem_pkg::LINE_BITS-1:0]                                store_wdata
);

    logic [main_mem_pkg::PORT_BITS-1:0] last_winner; // port granted most recently
    logic [main_mem_pkg::PORT_BITS-1:0] win;         // port granted this cycle
    logic                               found;       // any request this cycle

    // round robin, search starts just after the last winner
    always_comb begin
        int idx;
        found     = 1'b0;
        win       = '0;
        acc_grant = '0;
        for (int k = 1; k <= main_mem_pkg::NUM_PORTS; k++) begin
            idx = (int'(last_winner) + k) % main_mem_pkg::NUM_PORTS;
            if (!found && acc_req[idx]) begin
                found          = 1'b1;
                win            = main_mem_pkg::PORT_BITS'(idx);
                acc_grant[idx] = 1'b1;
            end
        end
    end

    // only changes when somebody wins
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_winner <= main_mem_pkg::PORT_BITS'(main_mem_pkg::NUM_PORTS - 1); // port 0 first
        end else if (found) begin
            last_winner <= win;
        end
    end

    // winner's access goes straight to the store
    assign store_en    = found;
    assign store_we    = found && acc_write[win];
    assign store_line  = acc_line[win];
    assign store_wdata = acc_wdata[win];

endmodule

`default_nettype wire

//--- design/mem_port_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_ctrl (
    input  wire logic                                    clk,
    input  wire logic                                    reset,
    input  wire logic                                    req_valid,
    output logic                                         req_ready,
    input  wire logic                                    req_write,
    input  wire logic [main_mem_pkg::ADDR_BITS-1:0]      req_addr,
    input  wire logic [main_mem_pkg::LINE_BITS-1:0]      req_wdata,
    output logic                                         resp_valid,
    output logic [main_mem_pkg::LINE_BITS-1:0]           resp_rdata,
    input  wire logic                                    resp_ready,
    output logic                                         acc_req,
    input  wire logic                                    acc_grant,
    output logic                                         acc_write,
    output logic [main_mem_pkg::LINE_IDX_BITS-1:0]       acc_line,
    output logic [main_mem_pkg::LINE_BITS-1:0]           acc_wdata,
    input  wire logic [main_mem_pkg::LINE_BITS-1:0]      store_rdata
);

    typedef enum logic [2:0] {
        ST_IDLE,    // ready for a new request
        ST_WAIT,    // counting down the access latency
        ST_ACCESS,  // asking the arbiter for the store
        ST_CAPTURE, // store data on the bus this cycle
        ST_RESPOND  // holding the answer under back-pressure
    } state_t;

    state_t state;
    logic [main_mem_pkg::LAT_CNT_BITS-1:0]  lat_cnt;   // cycles left in ST_WAIT
    logic                                   lat_write; // latched op
    logic [main_mem_pkg::LINE_IDX_BITS-1:0] lat_line;  // latched line index
    logic [main_mem_pkg::LINE_BITS-1:0]     lat_wdata; // latched write payload
    logic [main_mem_pkg::LINE_BITS-1:0]     resp_hold; // answer kept after capture

    logic accept;

    assign accept = req_valid && req_ready;

    // control path
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= ST_IDLE;
            lat_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state   <= ST_WAIT;
                        lat_cnt <= main_mem_pkg::LAT_CNT_BITS'(main_mem_pkg::ACCESS_LATENCY - 1);
                    end
                end
                ST_WAIT: begin
                    if (lat_cnt == '0) begin
                        state <= ST_ACCESS; // acc_req rises latency cycles after accept
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                ST_ACCESS: begin
                    if (acc_grant) begin
                        state <= ST_CAPTURE; // store works on this edge
                    end
                end
                ST_CAPTURE: begin
                    state <= resp_ready ? ST_IDLE : ST_RESPOND;
                end
                ST_RESPOND: begin
                    if (resp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload regs, no reset
    always_ff @(posedge clk) begin
        if (accept) begin
            lat_write <= req_write;
            lat_line  <= req_addr[main_mem_pkg::LINE_OFS_BITS +: main_mem_pkg::LINE_IDX_BITS];
            lat_wdata <= req_wdata;
        end
        if (state == ST_CAPTURE) begin
            resp_hold <= resp_rdata; // freeze before store_rdata can move
        end
    end

    assign req_ready  = (state == ST_IDLE);
    assign acc_req    = (state == ST_ACCESS);
    assign acc_write  = lat_write;
    assign acc_line   = lat_line;
    assign acc_wdata  = lat_wdata;
    assign resp_valid = (state == ST_CAPTURE) || (state == ST_RESPOND);

    // writes answer with zero
    always_comb begin
        if (state == ST_CAPTURE) begin
            resp_rdata = lat_write ? '0 : store_rdata;
        end else begin
            resp_rdata = resp_hold;
        end
    end

endmodule

`default_nettype wire

//--- design/main_mem_pkg.sv
`default_nettype none

package main_mem_pkg;

    // request and line geometry
    localparam int ADDR_BITS     = 32;                    // byte address
    localparam int LINE_BITS     = 128;                   // one cache line
    localparam int WORD_BITS     = 32;                    // one instruction word
    localparam int LINE_WORDS    = LINE_BITS / WORD_BITS; // 4 words per line
    localparam int LINE_OFS_BITS = $clog2(LINE_BITS / 8); // byte offset inside a line, ignored

    // store size
    localparam int MEM_WORDS     = 16384;                 // 64 KiB of words
    localparam int MEM_LINES     = MEM_WORDS / LINE_WORDS;
    localparam int LINE_IDX_BITS = $clog2(MEM_LINES);     // addr[15:4]

    // fixed access delay before a port may touch the store
    localparam int ACCESS_LATENCY = 10;
    localparam int LAT_CNT_BITS   = $clog2(ACCESS_LATENCY + 1);

    // requesters, port 0 = instruction, port 1 = data
    localparam int NUM_PORTS = 2;
    localparam int PORT_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    // preload contents
    localparam logic [WORD_BITS-1:0] NOP_WORD = 32'h0000_0013; // addi x0, x0, 0
    localparam int BOOT_WORD_BASE = 'h400;                     // pc 0x1000
    localparam int BOOT_COUNT     = 3;

    // word 0 sits in the low bits
    localparam logic [BOOT_COUNT*WORD_BITS-1:0] BOOT_WORDS = {
        32'h1020_0073, // sret
        32'h0000_9073, // move x1 into rm0
        32'h0500_0093  // addi x1, x0, 80
    };

endpackage

`default_nettype wire
